// ==== ahb_consts.svh ====
`ifndef AHB_CONSTS_SVH
`define AHB_CONSTS_SVH

// bus data width
`define AHB_DW 32

// RAM byte address width, 1 KB
`define RAM_AW 10

// haddr[31:28] region codes
`define RAM_BASE_NIBBLE  4'h0
`define GPIO_BASE_NIBBLE 4'h1

// GPIO register offsets within the region, haddr[27:0]
`define GPIO_OUT_OFS 28'h000_0000
`define GPIO_IN_OFS  28'h000_0004

`endif

// ==== ahb_bus_pkg.sv ====
`default_nettype none

package ahb_bus_pkg;

    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        hsize_byte = 3'b000,
        hsize_half = 3'b001,
        hsize_word = 3'b010
    } hsize_e;

    typedef enum logic {
        hresp_okay  = 1'b0,
        hresp_error = 1'b1
    } hresp_e;

    // little-endian lane enables for one transfer
    function automatic logic [3:0] lane_mask(hsize_e size, logic [1:0] ofs);
        logic [3:0] m;
        case (size)
            hsize_byte: m = 4'b0001 << ofs;
            hsize_half: m = ofs[1] ? 4'b1100 : 4'b0011;
            default:    m = 4'b1111;
        endcase
        return m;
    endfunction

endpackage

`default_nettype wire

// ==== soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

    typedef enum logic [1:0] {
        slave_none    = 2'b00,
        slave_ram     = 2'b01,
        slave_gpio    = 2'b10,
        slave_default = 2'b11
    } slave_e;

    typedef enum logic [1:0] {
        err_idle   = 2'b00,
        err_first  = 2'b01,
        err_second = 2'b10
    } err_state_e;

    // two-cycle error sequence, restartable from the second cycle
    function automatic err_state_e err_next(err_state_e cur, logic start);
        err_state_e nxt;
        if (start)
            nxt = err_first;
        else if (cur == err_first)
            nxt = err_second;
        else
            nxt = err_idle;
        return nxt;
    endfunction

endpackage

`default_nettype wire

// ==== byte_lane_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram
#(
    parameter int addr_width = 8
)
(
    input  wire logic                  HCLK,
    input  wire logic [addr_width-1:0] read_addr,
    input  wire logic [addr_width-1:0] write_addr,
    input  wire logic [7:0]            write_data,
    input  wire logic                  write_enable,
    output logic      [7:0]            read_data
);

    logic [7:0] mem [0:(1 << addr_width) - 1];

    always_ff @(posedge HCLK)
    begin
        if (write_enable)
            mem[write_addr] <= write_data;
        if (write_enable && write_addr == read_addr)
            read_data <= write_data; // write-first on a collision
        else
            read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// ==== ahb_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_ram_slave
    import ahb_bus_pkg::*;
#(
    parameter int addr_width = `RAM_AW
)
(
    input  wire logic               HCLK,
    input  wire logic               rst_n,
    input  wire logic               hsel,
    input  wire logic [31:0]        haddr,
    input  wire htrans_e            htrans,
    input  wire hsize_e             hsize,
    input  wire logic               hwrite,
    input  wire logic [`AHB_DW-1:0] hwdata,
    input  wire logic               hready,
    output wire logic [`AHB_DW-1:0] hrdata,
    output logic                    hreadyout,
    output hresp_e                  hresp
);

    logic                  accept;
    logic                  wr_q;
    logic [addr_width-3:0] addr_q;
    logic [3:0]            mask_q;

    assign accept = hsel && hready &&
                    (htrans == htrans_nonseq || htrans == htrans_seq);

    assign hreadyout = 1'b1; // zero wait states
    assign hresp     = hresp_okay;

    always_ff @(posedge HCLK or negedge rst_n)
    begin
        if (!rst_n)
            wr_q <= 1'b0;
        else
            wr_q <= accept && hwrite;
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
        begin
            addr_q <= haddr[addr_width-1:2];
            mask_q <= lane_mask(hsize, haddr[1:0]);
        end
    end

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        byte_lane_ram #(
            .addr_width (addr_width - 2)
        ) u_lane (
            .HCLK         (HCLK),
            .read_addr    (haddr[addr_width-1:2]), // address phase, data lands next cycle
            .write_addr   (addr_q),
            .write_data   (hwdata[i*8 +: 8]),
            .write_enable (wr_q && mask_q[i]),
            .read_data    (hrdata[i*8 +: 8])
        );
    end

endmodule

`default_nettype wire

// ==== ahb_gpio_slave.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_gpio_slave
    import ahb_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic               HCLK,
    input  wire logic               rst_n,
    input  wire logic               hsel,
    input  wire logic [31:0]        haddr,
    input  wire htrans_e            htrans,
    input  wire hsize_e             hsize,
    input  wire logic               hwrite,
    input  wire logic [`AHB_DW-1:0] hwdata,
    input  wire logic               hready,
    output logic      [`AHB_DW-1:0] hrdata,
    output logic                    hreadyout,
    output hresp_e                  hresp,
    input  wire logic [31:0]        gpio_in,
    output logic      [31:0]        gpio_out
);

    logic             accept;
    logic             is_out;
    logic             is_in;
    logic             legal;
    logic             wr_q;
    logic             rd_in_q;
    logic [3:0]       mask_q;
    logic [31:0]      in_meta;
    logic [31:0]      in_sync;
    err_state_e       err_state;

    assign accept = hsel && hready &&
                    (htrans == htrans_nonseq || htrans == htrans_seq);
    assign is_out = {haddr[27:2], 2'b00} == `GPIO_OUT_OFS; // any byte of the word
    assign is_in  = {haddr[27:2], 2'b00} == `GPIO_IN_OFS;
    assign legal  = is_out || (is_in && !hwrite); // input reg is read-only

    always_ff @(posedge HCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_q      <= 1'b0;
            rd_in_q   <= 1'b0;
            err_state <= err_idle;
            in_meta   <= '0;
            in_sync   <= '0;
            gpio_out  <= '0;
        end
        else
        begin
            wr_q      <= accept && legal && hwrite;
            err_state <= err_next(err_state, accept && !legal);
            in_meta   <= gpio_in;
            in_sync   <= in_meta;
            if (accept)
                rd_in_q <= is_in;
            for (int i = 0; i < 4; i++)
            begin
                if (wr_q && mask_q[i])
                    gpio_out[i*8 +: 8] <= hwdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
            mask_q <= lane_mask(hsize, haddr[1:0]);
    end

    assign hrdata    = rd_in_q ? in_sync : gpio_out;
    assign hreadyout = err_state != err_first;
    assign hresp     = (err_state == err_idle) ? hresp_okay : hresp_error;

endmodule

`default_nettype wire

// ==== ahb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_decoder
    import ahb_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic        HCLK,
    input  wire logic        rst_n,
    input  wire logic [31:0] haddr,
    input  wire htrans_e     htrans,
    input  wire logic        hready,
    output logic             hsel_ram,
    output logic             hsel_gpio,
    output slave_e           owner,
    output logic             def_hreadyout,
    output hresp_e           def_hresp
);

    logic       active;
    err_state_e def_state;

    assign active    = htrans == htrans_nonseq || htrans == htrans_seq;
    assign hsel_ram  = haddr[31:28] == `RAM_BASE_NIBBLE;
    assign hsel_gpio = haddr[31:28] == `GPIO_BASE_NIBBLE;

    always_comb
    begin
        if (!active)
            owner = slave_none;
        else if (hsel_ram)
            owner = slave_ram;
        else if (hsel_gpio)
            owner = slave_gpio;
        else
            owner = slave_default; // unmapped
    end

    // default slave
    always_ff @(posedge HCLK or negedge rst_n)
    begin
        if (!rst_n)
            def_state <= err_idle;
        else
            def_state <= err_next(def_state, hready && owner == slave_default);
    end

    assign def_hreadyout = def_state != err_first;
    assign def_hresp     = (def_state == err_idle) ? hresp_okay : hresp_error;

endmodule

`default_nettype wire

// ==== ahb_resp_mux.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_resp_mux
    import ahb_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic               HCLK,
    input  wire logic               rst_n,
    input  wire slave_e             owner,
    input  wire logic               hready_in,
    input  wire logic [`AHB_DW-1:0] ram_hrdata,
    input  wire logic               ram_hreadyout,
    input  wire hresp_e             ram_hresp,
    input  wire logic [`AHB_DW-1:0] gpio_hrdata,
    input  wire logic               gpio_hreadyout,
    input  wire hresp_e             gpio_hresp,
    input  wire logic               def_hreadyout,
    input  wire hresp_e             def_hresp,
    output logic      [`AHB_DW-1:0] hrdata,
    output logic                    hready,
    output hresp_e                  hresp
);

    slave_e owner_q; // data-phase owner

    always_ff @(posedge HCLK or negedge rst_n)
    begin
        if (!rst_n)
            owner_q <= slave_none;
        else if (hready_in)
            owner_q <= owner;
    end

    always_comb
    begin
        hrdata = '0;
        hready = 1'b1;
        hresp  = hresp_okay;
        case (owner_q)
            slave_ram:
            begin
                hrdata = ram_hrdata;
                hready = ram_hreadyout;
                hresp  = ram_hresp;
            end
            slave_gpio:
            begin
                hrdata = gpio_hrdata;
                hready = gpio_hreadyout;
                hresp  = gpio_hresp;
            end
            slave_default:
            begin
                hready = def_hreadyout;
                hresp  = def_hresp;
            end
            default: ; // idle/busy, zero-wait okay
        endcase
    end

endmodule

`default_nettype wire

// ==== ahb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_subsystem
    import ahb_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic               HCLK,
    input  wire logic               rst_n,
    input  wire logic [31:0]        haddr,
    input  wire htrans_e            htrans,
    input  wire hsize_e             hsize,
    input  wire logic               hwrite,
    input  wire logic [`AHB_DW-1:0] hwdata,
    output logic      [`AHB_DW-1:0] hrdata,
    output logic                    hready,
    output hresp_e                  hresp,
    input  wire logic [31:0]        gpio_in,
    output logic      [31:0]        gpio_out
);

    logic               hsel_ram;
    logic               hsel_gpio;
    slave_e             owner;
    logic               def_hreadyout;
    hresp_e             def_hresp;
    logic [`AHB_DW-1:0] ram_hrdata;
    logic               ram_hreadyout;
    hresp_e             ram_hresp;
    logic [`AHB_DW-1:0] gpio_hrdata;
    logic               gpio_hreadyout;
    hresp_e             gpio_hresp;

    ahb_decoder u_decoder (
        .HCLK          (HCLK),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hready        (hready),
        .hsel_ram      (hsel_ram),
        .hsel_gpio     (hsel_gpio),
        .owner         (owner),
        .def_hreadyout (def_hreadyout),
        .def_hresp     (def_hresp)
    );

    ahb_ram_slave #(
        .addr_width (`RAM_AW)
    ) u_ram (
        .HCLK      (HCLK),
        .rst_n     (rst_n),
        .hsel      (hsel_ram),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready    (hready),
        .hrdata    (ram_hrdata),
        .hreadyout (ram_hreadyout),
        .hresp     (ram_hresp)
    );

    ahb_gpio_slave u_gpio (
        .HCLK      (HCLK),
        .rst_n     (rst_n),
        .hsel      (hsel_gpio),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready    (hready),
        .hrdata    (gpio_hrdata),
        .hreadyout (gpio_hreadyout),
        .hresp     (gpio_hresp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    ahb_resp_mux u_mux (
        .HCLK           (HCLK),
        .rst_n          (rst_n),
        .owner          (owner),
        .hready_in      (hready), // own output fed back
        .ram_hrdata     (ram_hrdata),
        .ram_hreadyout  (ram_hreadyout),
        .ram_hresp      (ram_hresp),
        .gpio_hrdata    (gpio_hrdata),
        .gpio_hreadyout (gpio_hreadyout),
        .gpio_hresp     (gpio_hresp),
        .def_hreadyout  (def_hreadyout),
        .def_hresp      (def_hresp),
        .hrdata         (hrdata),
        .hready         (hready),
        .hresp          (hresp)
    );

endmodule

`default_nettype wire

// ==== ahb_subsystem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module ahb_subsystem_assertions
    import ahb_bus_pkg::*;
(
    input wire logic        HCLK,
    input wire logic        rst_n,
    input wire logic [31:0] haddr,
    input wire htrans_e     htrans,
    input wire logic        hwrite,
    input wire logic        hready,
    input wire hresp_e      hresp,
    input wire logic [31:0] gpio_out
);

    logic gpio_wr; // accepted write into the GPIO region

    assign gpio_wr = hready && hwrite && haddr[31:28] == `GPIO_BASE_NIBBLE &&
                     (htrans == htrans_nonseq || htrans == htrans_seq);

    error_two_cycles: assert property (@(posedge HCLK) disable iff (!rst_n)
        (hresp == hresp_error && !hready) |=> (hresp == hresp_error && hready))
        else $error("error response not completed in its second cycle");

    ready_after_reset: assert property (@(posedge HCLK)
        $rose(rst_n) |-> hready)
        else $error("hready low right after reset");

    // output register is written at the end of the data phase
    gpio_out_on_write: assert property (@(posedge HCLK) disable iff (!rst_n)
        !$stable(gpio_out) |-> $past(gpio_wr, 2))
        else $error("gpio_out changed without a GPIO write");

endmodule

bind ahb_subsystem ahb_subsystem_assertions u_protocol_checks (
    .HCLK     (HCLK),
    .rst_n    (rst_n),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hready   (hready),
    .hresp    (hresp),
    .gpio_out (gpio_out)
);

`default_nettype wire

// ==== tb_ahb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ahb_consts.svh"

module tb_ahb_subsystem
    import ahb_bus_pkg::*;
();

    localparam int clk_period = 20;
    // words, lanes, gpio, errors, idle
    localparam int num_transfers = 128 + 26 + 7 + 6 + 9;
    localparam logic [31:0] gpio_out_addr = {`GPIO_BASE_NIBBLE, `GPIO_OUT_OFS};
    localparam logic [31:0] gpio_in_addr  = {`GPIO_BASE_NIBBLE, `GPIO_IN_OFS};
    localparam logic [31:0] gpio_bad_addr = {`GPIO_BASE_NIBBLE, 28'h000_0008};
    localparam logic [31:0] unmapped_addr = 32'h2000_0010; // low bits alias RAM word 0x10

    logic        HCLK;
    logic        rst_n;
    logic [31:0] haddr;
    htrans_e     htrans;
    hsize_e      hsize;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    hresp_e      hresp;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;

    logic [7:0]  ram_model [0:(1 << `RAM_AW) - 1];
    logic [31:0] gpio_model;
    integer      seed;

    ahb_subsystem UUT (
        .HCLK     (HCLK),
        .rst_n    (rst_n),
        .haddr    (haddr),
        .htrans   (htrans),
        .hsize    (hsize),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    initial HCLK = 1'b0;
    always #(clk_period / 2) HCLK = ~HCLK;

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            fail_run();
        end
    endtask

    // byte k of an aligned group sits on lane addr % 4
    task automatic model_write(input logic [31:0] addr, input hsize_e size,
                               input logic [31:0] data);
        int nbytes;
        int base;
        int lane;
        case (size)
            hsize_byte: nbytes = 1;
            hsize_half: nbytes = 2;
            default:    nbytes = 4;
        endcase
        base = int'(addr[`RAM_AW-1:0]) & ~(nbytes - 1);
        for (int k = 0; k < nbytes; k++)
        begin
            lane = (base + k) % 4;
            if (addr[31:28] == `RAM_BASE_NIBBLE)
                ram_model[base + k] = data[lane*8 +: 8];
            else
                gpio_model[lane*8 +: 8] = data[lane*8 +: 8];
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        int base;
        base = int'(addr[`RAM_AW-1:0]) & ~3;
        if (addr[31:28] == `GPIO_BASE_NIBBLE)
            return gpio_model;
        return {ram_model[base + 3], ram_model[base + 2], ram_model[base + 1], ram_model[base]};
    endfunction

    // single transfer followed by idle until the data phase ends at a negedge
    task automatic do_transfer(input logic [31:0] addr, input logic wr, input hsize_e size,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output hresp_e resp, output int stalls);
        @(posedge HCLK);
        haddr  <= addr;
        htrans <= htrans_nonseq;
        hsize  <= size;
        hwrite <= wr;
        @(posedge HCLK); // address phase accepted here
        htrans <= htrans_idle;
        hwdata <= wr ? wdata : 32'h0;
        stalls = 0;
        @(negedge HCLK);
        while (!hready)
        begin
            check_value("hresp", 32'(hresp_error), 32'(hresp));
            stalls++;
            @(negedge HCLK);
        end
        rdata = hrdata;
        resp  = hresp;
    endtask

    task automatic bus_write(input logic [31:0] addr, input hsize_e size,
                             input logic [31:0] data);
        logic [31:0] rdata;
        hresp_e      resp;
        int          stalls;
        do_transfer(addr, 1'b1, size, data, rdata, resp, stalls);
        check_value("hresp", 32'(hresp_okay), 32'(resp));
        check_value("stall cycles", 32'd0, 32'(stalls));
        model_write(addr, size, data);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        hresp_e      resp;
        int          stalls;
        do_transfer(addr, 1'b0, hsize_word, 32'h0, rdata, resp, stalls);
        check_value("hresp", 32'(hresp_okay), 32'(resp));
        check_value("stall cycles", 32'd0, 32'(stalls));
        check_value("hrdata", exp, rdata);
    endtask

    task automatic bus_expect_error(input logic [31:0] addr, input logic wr);
        logic [31:0] rdata;
        hresp_e      resp;
        int          stalls;
        do_transfer(addr, wr, hsize_word, $random(seed), rdata, resp, stalls);
        check_value("hresp", 32'(hresp_error), 32'(resp));
        check_value("stall cycles", 32'd1, 32'(stalls));
    endtask

    // idle or busy cycle that looks like a write
    task automatic bus_idle(input logic [31:0] addr, input htrans_e kind);
        @(posedge HCLK);
        haddr  <= addr;
        htrans <= kind;
        hsize  <= hsize_word;
        hwrite <= 1'b1;
        @(posedge HCLK);
        htrans <= htrans_idle;
        hwdata <= $random(seed);
        @(negedge HCLK);
        check_value("hready", 32'd1, 32'(hready));
        check_value("hresp", 32'(hresp_okay), 32'(hresp));
    endtask

    task automatic check_gpio_pins();
        @(negedge HCLK);
        check_value("gpio_out", gpio_model, gpio_out);
    endtask

    task automatic test_reset();
        @(negedge HCLK);
        check_value("hready", 32'd1, 32'(hready));
        check_value("hresp", 32'(hresp_okay), 32'(hresp));
        check_value("gpio_out", 32'h0, gpio_out);
    endtask

    task automatic test_ram_words();
        for (int i = 0; i < 64; i++)
            bus_write(32'(i * 16), hsize_word, $random(seed));
        for (int i = 0; i < 64; i++)
            bus_read(32'(i * 16), model_read(32'(i * 16)));
    endtask

    task automatic test_ram_lanes();
        logic [31:0] base;
        for (int w = 0; w < 2; w++)
        begin
            base = (w == 0) ? 32'h100 : 32'h204;
            bus_write(base, hsize_word, $random(seed));
            for (int ofs = 0; ofs < 4; ofs++)
            begin
                bus_write(base + 32'(ofs), hsize_byte, $random(seed));
                bus_read(base, model_read(base));
            end
            for (int ofs = 0; ofs < 4; ofs += 2)
            begin
                bus_write(base + 32'(ofs), hsize_half, $random(seed));
                bus_read(base, model_read(base));
            end
        end
    endtask

    task automatic test_gpio();
        logic [31:0] pins;
        bus_write(gpio_out_addr, hsize_word, $random(seed));
        check_gpio_pins();
        bus_read(gpio_out_addr, gpio_model);
        bus_write(gpio_out_addr + 32'd1, hsize_byte, $random(seed));
        check_gpio_pins();
        bus_read(gpio_out_addr, gpio_model);
        bus_write(gpio_out_addr + 32'd2, hsize_half, $random(seed));
        check_gpio_pins();
        bus_read(gpio_out_addr, gpio_model);
        pins = $random(seed);
        @(posedge HCLK);
        gpio_in <= pins;
        repeat (3) @(posedge HCLK); // synchronizer delay
        bus_read(gpio_in_addr, pins);
    endtask

    task automatic test_errors();
        bus_expect_error(unmapped_addr, 1'b1);
        bus_expect_error(unmapped_addr, 1'b0);
        bus_expect_error(gpio_bad_addr, 1'b1);
        bus_expect_error(gpio_in_addr, 1'b1);
        check_gpio_pins();
        bus_read(gpio_out_addr, gpio_model);
        bus_read(32'h10, model_read(32'h10));
    endtask

    task automatic test_idle();
        bus_write(32'h3f0, hsize_word, $random(seed));
        bus_idle(unmapped_addr, htrans_idle);
        bus_write(32'h3f4, hsize_word, $random(seed));
        bus_idle(32'h3f0, htrans_busy);
        bus_read(32'h3f0, model_read(32'h3f0));
        bus_idle(32'h3f4, htrans_idle);
        bus_read(32'h3f4, model_read(32'h3f4));
        bus_idle(gpio_out_addr, htrans_idle);
        bus_read(gpio_out_addr, gpio_model);
    endtask

    initial
    begin
        #((num_transfers * 4 + 200) * clk_period);
        $display("timeout: the bus transfers did not complete in time");
        fail_run();
    end

    initial
    begin
        seed = 32'h5588;
        gpio_model = 32'h0;
        rst_n   <= 1'b0;
        haddr   <= 32'h0;
        htrans  <= htrans_idle;
        hsize   <= hsize_word;
        hwrite  <= 1'b0;
        hwdata  <= 32'h0;
        gpio_in <= 32'h0;
        repeat (5) @(posedge HCLK);
        rst_n <= 1'b1;
        test_reset();
        test_ram_words();
        test_ram_lanes();
        test_gpio();
        test_errors();
        test_idle();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
ahb_bus_pkg.sv
soc_map_pkg.sv
byte_lane_ram.sv
ahb_ram_slave.sv
ahb_gpio_slave.sv
ahb_decoder.sv
ahb_resp_mux.sv
ahb_subsystem.sv
ahb_subsystem_assertions.sv
tb_ahb_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_ahb_subsystem -o sim_tb
./obj_dir/sim_tb
